/* verilog/adder_settings.svh */
`ifndef ADDER_SETTINGS_SVH
`define ADDER_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adder geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ADDER_WIDTH 32 // bits per operand

`define PREFIX_STAGES 5 // log2 of the width, one span doubling per stage

// encoder register, one register per prefix stage, then the sum register
`define ADDER_LATENCY (`PREFIX_STAGES + 2)

`endif

/* verilog/operand_pkg.sv */
`include "adder_settings.svh"

package operand_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data words seen at the adder boundary
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one operand, one sum, or one bit per position such as the carry word
	typedef logic [`ADDER_WIDTH-1:0] operand_t;

endpackage

/* verilog/prefix_pkg.sv */
`include "adder_settings.svh"

package prefix_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// carry pairs used inside the prefix network
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic prop; // carry out of the group if the lower neighbor carries
		logic gen; // carry out of the group in any case
	} pgk_pair_t;

	// one pair per bit position, position 0 at the bottom
	typedef pgk_pair_t [`ADDER_WIDTH-1:0] pgk_vector_t;

endpackage

/* verilog/pgk_encoder.sv */
`timescale 1ns/100ps

`include "adder_settings.svh"

module pgk_encoder (
	input  logic                  clock,
	input  logic                  arst_n,
	input  operand_pkg::operand_t a,
	input  operand_pkg::operand_t b,
	output prefix_pkg::pgk_vector_t pgk,
	output operand_pkg::operand_t half_sum
);

	prefix_pkg::pgk_vector_t pgk_next;
	operand_pkg::operand_t   half_sum_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per bit pair encoding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < `ADDER_WIDTH; i++) begin
			pgk_next[i].gen  = a[i] & b[i];
			pgk_next[i].prop = a[i] | b[i];
		end
		pgk_next[0].prop = a[0] & b[0]; // no carry in, so bit 0 already knows its carry
	end

	assign half_sum_next = a ^ b;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pgk      <= '0;
			half_sum <= '0;
		end else begin
			pgk      <= pgk_next;
			half_sum <= half_sum_next; // travels beside pgk into the sum delay line
		end
	end

endmodule

/* verilog/prefix_network.sv */
`timescale 1ns/100ps

`include "adder_settings.svh"

module prefix_network (
	input  logic                    clock,
	input  logic                    arst_n,
	input  prefix_pkg::pgk_vector_t pgk,
	output operand_pkg::operand_t   carry
);

	// level 0 is the encoder output, level k+1 the register of stage k
	prefix_pkg::pgk_vector_t level [0:`PREFIX_STAGES];

	assign level[0] = pgk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// doubling span stages
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar k = 0; k < `PREFIX_STAGES; k++) begin : g_stage
		localparam int SPAN = 1 << k;

		prefix_pkg::pgk_vector_t merged;
		prefix_pkg::pgk_vector_t stage_q;

		for (genvar i = 0; i < `ADDER_WIDTH; i++) begin : g_pos
			if (i >= SPAN) begin : g_merge
				// group i absorbs the group that ends one span lower
				assign merged[i].gen = level[k][i].gen
					| (level[k][i].prop & level[k][i-SPAN].gen);
				assign merged[i].prop = level[k][i].gen
					| (level[k][i].prop & level[k][i-SPAN].prop);
			end else begin : g_pass
				assign merged[i] = level[k][i]; // already reaches down to bit 0
			end
		end

		always_ff @(posedge clock or negedge arst_n) begin
			if (!arst_n) begin
				stage_q <= '0;
			end else begin
				stage_q <= merged;
			end
		end

		assign level[k+1] = stage_q;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// carry extraction
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// every group now spans down to bit 0, so both fields hold the carry out
	always_comb begin
		for (int i = 0; i < `ADDER_WIDTH; i++) begin
			carry[i] = level[`PREFIX_STAGES][i].gen;
		end
	end

endmodule

/* verilog/sum_former.sv */
`timescale 1ns/100ps

`include "adder_settings.svh"

module sum_former (
	input  logic                  clock,
	input  logic                  arst_n,
	input  operand_pkg::operand_t half_sum,
	input  operand_pkg::operand_t carry,
	output operand_pkg::operand_t sum,
	output logic                  cout
);

	// one slot per prefix stage keeps the half sum in step with carry
	operand_pkg::operand_t half_sum_pipe [`PREFIX_STAGES];
	operand_pkg::operand_t carry_in;
	operand_pkg::operand_t sum_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// half sum delay line
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `PREFIX_STAGES; i++) begin
				half_sum_pipe[i] <= '0;
			end
		end else begin
			half_sum_pipe[0] <= half_sum;
			for (int i = 1; i < `PREFIX_STAGES; i++) begin
				half_sum_pipe[i] <= half_sum_pipe[i-1];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sum formation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign carry_in = {carry[`ADDER_WIDTH-2:0], 1'b0}; // carry into bit i comes out of bit i-1
	assign sum_next = half_sum_pipe[`PREFIX_STAGES-1] ^ carry_in;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			sum  <= '0;
			cout <= 1'b0;
		end else begin
			sum  <= sum_next;
			cout <= carry[`ADDER_WIDTH-1]; // carry out of the top position
		end
	end

endmodule

/* verilog/cla_adder.sv */
`timescale 1ns/100ps

module cla_adder (
	input  logic                  clock,
	input  logic                  arst_n,
	input  operand_pkg::operand_t a,
	input  operand_pkg::operand_t b,
	output operand_pkg::operand_t sum,
	output logic                  cout
);

	prefix_pkg::pgk_vector_t pgk;
	operand_pkg::operand_t   half_sum;
	operand_pkg::operand_t   carry;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// encoder, prefix network, sum
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	pgk_encoder encoder (
		.clock    (clock),
		.arst_n   (arst_n),
		.a        (a),
		.b        (b),
		.pgk      (pgk),
		.half_sum (half_sum)
	);

	prefix_network network (
		.clock  (clock),
		.arst_n (arst_n),
		.pgk    (pgk),
		.carry  (carry)
	);

	sum_former former (
		.clock    (clock),
		.arst_n   (arst_n),
		.half_sum (half_sum),
		.carry    (carry),
		.sum      (sum),
		.cout     (cout)
	);

endmodule

/* sim/cla_adder_tb.sv */
`timescale 1ns/100ps

`include "adder_settings.svh"

module cla_adder_tb;

	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int MID_RESET_CYCLES = 4;
	localparam int RANDOM_PAIRS = 200;
	localparam int MID_PAIRS_BEFORE = 12;
	localparam int MID_PAIRS_AFTER = 20;
	localparam int VECTOR_COUNT = 4 + 2 + RANDOM_PAIRS + MID_PAIRS_BEFORE + MID_PAIRS_AFTER
		+ 2 * `ADDER_LATENCY;
	// every test drains the pipeline once, plus some slack
	localparam int TIMEOUT_CYCLES = VECTOR_COUNT + RESET_CYCLES + MID_RESET_CYCLES
		+ 5 * (`ADDER_LATENCY + 2) + 50;

	localparam operand_pkg::operand_t ALL_ONES = '1;
	localparam operand_pkg::operand_t TOP_BIT = {1'b1, {(`ADDER_WIDTH-1){1'b0}}};
	localparam operand_pkg::operand_t PATTERN_A = {(`ADDER_WIDTH/2){2'b10}};
	localparam operand_pkg::operand_t PATTERN_5 = {(`ADDER_WIDTH/2){2'b01}};

	logic                  clock;
	logic                  arst_n;
	operand_pkg::operand_t a;
	operand_pkg::operand_t b;
	operand_pkg::operand_t sum;
	logic                  cout;

	int edge_count = 0; // rising edges seen so far
	logic [31:0] rng_state = 32'hc5a8cd33;

	logic [`ADDER_WIDTH:0] expected_q [$];
	int due_q [$]; // edge after which each expected result must show
	int discard_upto = 0;
	int release_edge = -1000;
	int check_index = 0;

	int check_count = 0;
	int error_count = 0;
	int test_count = 0;
	int test_checks_start = 0;
	int test_errors_start = 0;

	cla_adder uut (
		.clock  (clock),
		.arst_n (arst_n),
		.a      (a),
		.b      (b),
		.sum    (sum),
		.cout   (cout)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model and helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// carry out in the top bit, sum below
	function automatic logic [`ADDER_WIDTH:0] add_reference(input operand_pkg::operand_t x,
		input operand_pkg::operand_t y);
		return {1'b0, x} + {1'b0, y};
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_value(input string name, input operand_pkg::operand_t expected,
		input operand_pkg::operand_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic drive_pair(input operand_pkg::operand_t x, input operand_pkg::operand_t y);
		@(posedge clock);
		a <= x;
		b <= y;
		expected_q.push_back(add_reference(x, y));
		due_q.push_back(edge_count + `ADDER_LATENCY); // shows after the latency count of edges
	endtask

	task automatic drive_random(input int count);
		repeat (count) begin
			drive_pair(operand_pkg::operand_t'(next_random()),
				operand_pkg::operand_t'(next_random()));
		end
	endtask

	task automatic release_reset();
		@(posedge clock);
		arst_n <= 1'b1;
		release_edge = edge_count;
		repeat (`ADDER_LATENCY) begin
			drive_pair('0, '0); // zero inputs while the pipeline refills
		end
	endtask

	task automatic begin_test();
		test_checks_start = check_count;
		test_errors_start = error_count;
	endtask

	task automatic end_test(input string name);
		do begin
			@(negedge clock);
		end while (check_index < due_q.size() || edge_count <= release_edge + `ADDER_LATENCY);
		test_count++;
		$display("%-26s %0d checks, %0d mismatches", name, check_count - test_checks_start,
			error_count - test_errors_start);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// clock, comparison and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		clock = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2);
			edge_count = edge_count + 1; // counted before the edge so drivers see the new value
			clock = 1'b1;
			#(CLOCK_PERIOD / 2);
			clock = 1'b0;
		end
	end

	// outputs are compared on the falling edge, halfway between updates
	initial begin
		forever begin
			@(negedge clock);
			if (check_index < discard_upto) begin
				check_index = discard_upto; // pairs lost to a reset
			end
			if (!arst_n || edge_count <= release_edge + `ADDER_LATENCY) begin
				check_value("sum", '0, sum);
				check_value("cout", '0, operand_pkg::operand_t'(cout));
			end
			while (check_index < due_q.size() && due_q[check_index] <= edge_count) begin
				if (due_q[check_index] < edge_count) begin
					error_count++;
					$display("ERROR at %0t ns: the result of pair %0d was never compared",
						$time, check_index);
				end else begin
					check_value("sum", expected_q[check_index][`ADDER_WIDTH-1:0], sum);
					check_value("cout",
						operand_pkg::operand_t'(expected_q[check_index][`ADDER_WIDTH]),
						operand_pkg::operand_t'(cout));
				end
				check_index++;
			end
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		arst_n <= 1'b0;
		a <= '0;
		b <= '0;

		begin_test();
		repeat (RESET_CYCLES) @(posedge clock);
		release_reset();
		end_test("reset state");

		begin_test();
		drive_pair('0, '0);
		drive_pair(ALL_ONES, operand_pkg::operand_t'(1)); // carry ripples through every bit
		drive_pair(ALL_ONES, ALL_ONES);
		drive_pair(TOP_BIT, TOP_BIT);
		end_test("corner operands");

		begin_test();
		drive_pair(PATTERN_A, PATTERN_5); // propagate at every position
		drive_pair(PATTERN_A, PATTERN_5 + operand_pkg::operand_t'(1));
		end_test("alternating patterns");

		begin_test();
		drive_random(RANDOM_PAIRS);
		end_test("back to back random pairs");

		begin_test();
		drive_random(MID_PAIRS_BEFORE);
		@(posedge clock);
		arst_n <= 1'b0;
		a <= '0;
		b <= '0;
		discard_upto = due_q.size();
		repeat (MID_RESET_CYCLES) @(posedge clock);
		release_reset();
		drive_random(MID_PAIRS_AFTER);
		end_test("reset during traffic");

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+verilog
verilog/operand_pkg.sv
verilog/prefix_pkg.sv
verilog/pgk_encoder.sv
verilog/prefix_network.sv
verilog/sum_former.sv
verilog/cla_adder.sv
sim/cla_adder_tb.sv

/* Makefile */
# Verilator build and run for the pipelined carry-lookahead adder

VERILATOR ?= verilator
TOP ?= cla_adder_tb
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -j 0
FILE_LIST ?= compile.f
PASS_TEXT ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := $(wildcard verilog/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
